// ==== hw/rsa_map_pkg.sv ====
package rsa_map_pkg;

  // row geometry
  localparam int LANES     = 4;
  localparam int RSA_DW    = 16;
  localparam int ADDR_W    = 4;
  localparam int BANK_ROWS = 1 << ADDR_W;

  // sequence and selector widths
  localparam int SEQ_W   = 5;
  localparam int SEQ_LEN = 16;
  localparam int SEL_W   = 5;

  // one matrix element, lane 0 sits in the low bits of a row
  typedef logic signed [RSA_DW-1:0] lane_t;
  typedef lane_t [LANES-1:0]        row_t;
  typedef logic [ADDR_W-1:0]        addr_t;
  typedef logic [SEQ_W-1:0]         seq_t;
  typedef logic [SEL_W-1:0]         sel_t;

  // selector splits into group (upper three) and direction (lower two)
  typedef logic [SEL_W-3:0] grp_t;
  typedef logic [1:0]       dir_t;

  localparam grp_t GRP_IDLE          = 3'b000;
  localparam grp_t GRP_B             = 3'b001;
  localparam grp_t GRP_H_TRANSPOSE   = 3'b101;
  localparam grp_t GRP_COV_TRANSPOSE = 3'b110;

  localparam dir_t DIR_IDLE = 2'b00;
  localparam dir_t DIR_POS  = 2'b01;
  localparam dir_t DIR_NEG  = 2'b10;
  localparam dir_t DIR_NEW  = 2'b11;

  typedef struct packed {
    sel_t  sel;
    logic  l_k_0;
    addr_t base;
  } map_cmd_t;

  typedef enum logic {ST_IDLE, ST_RUN} ctrl_state_t;

endpackage

// ==== hw/tb_bank.sv ====
`timescale 1ns/1ps

module tb_bank
  import rsa_map_pkg::*;
(
  input  logic  clk,
  // write port, open every cycle
  input  logic  wr_en,
  input  addr_t wr_addr,
  input  row_t  wr_row,
  // registered read port
  input  logic  rd_en,
  input  addr_t rd_addr,
  output row_t  rd_row
);

  // row storage
  row_t mem [BANK_ROWS];

  // synchronous write
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_row;
    end
  end

  // read data lands one cycle after the address
  // same-address write in that cycle is not seen yet
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_row <= mem[rd_addr];
    end
  end

endmodule

// ==== hw/map_ctrl_regs.sv ====
`timescale 1ns/1ps

module map_ctrl_regs
  import rsa_map_pkg::*;
(
  input  logic     clk,
  input  logic     sys_rst,
  // command strobe, dropped while busy
  input  logic     cmd_valid,
  input  map_cmd_t cmd,
  output logic     busy,
  // bank read side
  output logic     rd_en,
  output addr_t    rd_addr,
  // mapper steering, aligned to bank read data
  output sel_t     map_sel,
  output logic     map_l_k_0,
  output seq_t     map_seq,
  output logic     map_active
);

  // one pipeline stage of steering fields
  typedef struct packed {
    logic active;
    sel_t sel;
    logic l_k_0;
    seq_t seq;
  } map_dly_t;

  ctrl_state_t state;
  map_cmd_t    cmd_q;
  seq_t        cnt;
  logic        last_step;
  map_dly_t    dly_d;
  map_dly_t    dly_q;

  // step 15 ends the command
  assign last_step = (cnt == seq_t'(SEQ_LEN - 1));

  // command latch and step counter
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state <= ST_IDLE;
      cnt   <= '0;
      cmd_q <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (cmd_valid) begin
            cmd_q <= cmd;
            cnt   <= '0;
            state <= ST_RUN;
          end
        end
        ST_RUN: begin
          if (last_step) begin
            state <= ST_IDLE;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign busy  = (state == ST_RUN);
  assign rd_en = busy;

  // row address wraps mod 16 past the last bank row
  assign rd_addr = cmd_q.base + addr_t'(cnt);

  // idle steering is forced to the idle group
  always_comb begin
    dly_d.active = rd_en;
    dly_d.sel    = rd_en ? cmd_q.sel : {GRP_IDLE, DIR_IDLE};
    dly_d.l_k_0  = rd_en & cmd_q.l_k_0;
    dly_d.seq    = rd_en ? cnt : '0;
  end

  // matches the bank read latency
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      dly_q <= '0;
    end else begin
      dly_q <= dly_d;
    end
  end

  assign map_active = dly_q.active;
  assign map_sel    = dly_q.sel;
  assign map_l_k_0  = dly_q.l_k_0;
  assign map_seq    = dly_q.seq;

endmodule

// ==== hw/tb_doutb_map.sv ====
`timescale 1ns/1ps

module tb_doutb_map
  import rsa_map_pkg::*;
(
  input  logic clk,
  input  logic sys_rst,
  // steering from the control block
  input  sel_t sel,
  input  logic l_k_0,
  input  seq_t seq_cnt,
  input  logic active,
  // bank row being routed
  input  row_t doutb,
  // registered outputs
  output row_t b_row,
  output row_t dina_row,
  output logic out_valid
);

  grp_t  grp;
  dir_t  dir;
  logic  hold_en;
  row_t  b_nxt;
  row_t  dina_nxt;

  // held cov elements for the landmark transpose
  lane_t h03;
  lane_t h04;
  lane_t h13;
  lane_t h14;

  // write-back rows only ever fill lanes 0 and 1
  function automatic row_t pair_row(input lane_t lo, input lane_t hi);
    row_t r;
    r    = '0;
    r[0] = lo;
    r[1] = hi;
    return r;
  endfunction

  assign grp = sel[SEL_W-1:2];
  assign dir = sel[1:0];

  // B side row
  always_comb begin
    b_nxt = '0;
    if (grp == GRP_B) begin
      case (dir)
        DIR_POS: begin
          b_nxt = doutb;
        end
        DIR_NEG: begin
          // lane order reversed
          for (int i = 0; i < LANES; i++) begin
            b_nxt[i] = doutb[LANES-1-i];
          end
        end
        DIR_NEW: begin
          // flag picks the low or the high half
          if (l_k_0) begin
            b_nxt = pair_row(doutb[0], doutb[1]);
          end else begin
            b_nxt = pair_row(doutb[2], doutb[3]);
          end
        end
        default: begin
          b_nxt = '0;
        end
      endcase
    end
  end

  // write-back row
  always_comb begin
    dina_nxt = '0;
    case (grp)
      GRP_H_TRANSPOSE: begin
        // 2x2 transpose over counts 12 to 14
        case (seq_cnt)
          5'd12:   dina_nxt = pair_row(doutb[0], '0);
          5'd13:   dina_nxt = pair_row(doutb[1], doutb[0]);
          5'd14:   dina_nxt = pair_row('0, doutb[1]);
          default: dina_nxt = '0;
        endcase
      end
      GRP_COV_TRANSPOSE: begin
        // 2x3 transpose over counts 4 to 10
        case (seq_cnt)
          5'd4:    dina_nxt = pair_row(doutb[0], '0);
          5'd5:    dina_nxt = pair_row(doutb[1], doutb[0]);
          5'd6:    dina_nxt = pair_row(doutb[2], doutb[1]);
          5'd7:    dina_nxt = pair_row('0, doutb[2]);
          5'd8: begin
            // landmark case replays held elements
            if (l_k_0) begin
              dina_nxt = pair_row(h03, '0);
            end else begin
              dina_nxt = pair_row(doutb[2], '0);
            end
          end
          5'd9: begin
            if (l_k_0) begin
              dina_nxt = pair_row(h04, h13);
            end else begin
              dina_nxt = pair_row(doutb[3], doutb[2]);
            end
          end
          5'd10: begin
            if (l_k_0) begin
              dina_nxt = pair_row('0, h14);
            end else begin
              dina_nxt = pair_row('0, doutb[3]);
            end
          end
          default: dina_nxt = '0;
        endcase
      end
      default: begin
        dina_nxt = '0;
      end
    endcase
  end

  // capture only in the landmark cov transpose
  assign hold_en = (grp == GRP_COV_TRANSPOSE) && l_k_0;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      h03 <= '0;
      h04 <= '0;
      h13 <= '0;
      h14 <= '0;
    end else if (hold_en) begin
      case (seq_cnt)
        5'd6: begin
          h03 <= doutb[0];
        end
        5'd7: begin
          h13 <= doutb[0];
          h04 <= doutb[1];
        end
        5'd8: begin
          h14 <= doutb[1];
        end
        default: begin
          h03 <= h03;
        end
      endcase
    end
  end

  // output stage
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      b_row     <= '0;
      dina_row  <= '0;
      out_valid <= 1'b0;
    end else begin
      b_row     <= b_nxt;
      dina_row  <= dina_nxt;
      out_valid <= active;
    end
  end

endmodule

// ==== hw/map_top.sv ====
`timescale 1ns/1ps

module map_top
  import rsa_map_pkg::*;
(
  input  logic     clk,
  input  logic     sys_rst,
  // direct bank preload
  input  logic     wr_en,
  input  addr_t    wr_addr,
  input  row_t     wr_row,
  // command strobe
  input  logic     cmd_valid,
  input  map_cmd_t cmd,
  output logic     busy,
  // routed rows, valid as a level
  output logic     out_valid,
  output row_t     b_row,
  output row_t     dina_row
);

  // bank read path
  logic  rd_en;
  addr_t rd_addr;
  row_t  rd_row;

  // steering aligned with rd_row
  sel_t  map_sel;
  logic  map_l_k_0;
  seq_t  map_seq;
  logic  map_active;

  tb_bank bank_inst (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_row  (wr_row),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_row  (rd_row)
  );

  map_ctrl_regs ctrl_inst (
    .clk        (clk),
    .sys_rst    (sys_rst),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .busy       (busy),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .map_sel    (map_sel),
    .map_l_k_0  (map_l_k_0),
    .map_seq    (map_seq),
    .map_active (map_active)
  );

  // mapper adds the third cycle of latency
  tb_doutb_map map_inst (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .sel       (map_sel),
    .l_k_0     (map_l_k_0),
    .seq_cnt   (map_seq),
    .active    (map_active),
    .doutb     (rd_row),
    .b_row     (b_row),
    .dina_row  (dina_row),
    .out_valid (out_valid)
  );

endmodule

// ==== bench/map_top_sva.sv ====
`timescale 1ns/1ps

module map_top_sva
  import rsa_map_pkg::*;
(
  input logic clk,
  input logic sys_rst,
  input logic cmd_valid,
  input logic busy,
  input logic out_valid,
  input row_t b_row,
  input row_t dina_row
);

  logic       accepted;
  logic [4:0] busy_run;

  // strobe only counts while idle
  assign accepted = cmd_valid && !busy;

  // length of the current busy stretch
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      busy_run <= '0;
    end else if (busy) begin
      busy_run <= busy_run + 5'd1;
    end else begin
      busy_run <= '0;
    end
  end

  a_quiet_rows: assert property (@(posedge clk) disable iff (sys_rst)
    !out_valid |-> (b_row == '0) && (dina_row == '0))
    else $error("rows not zero while out_valid is low");

  a_busy_start: assert property (@(posedge clk) disable iff (sys_rst)
    accepted |=> busy)
    else $error("busy did not follow an accepted command");

  a_busy_len: assert property (@(posedge clk) disable iff (sys_rst)
    $fell(busy) |-> (busy_run == 5'd16))
    else $error("busy stretch was not 16 cycles");

  a_busy_max: assert property (@(posedge clk) disable iff (sys_rst)
    busy |-> (busy_run < 5'd16))
    else $error("busy held longer than 16 cycles");

  // three stages: command latch, bank read, mapper register
  a_valid_lat: assert property (@(posedge clk) disable iff (sys_rst)
    accepted |-> ##3 $rose(out_valid))
    else $error("out_valid did not rise 3 cycles after the command");

  a_dina_upper: assert property (@(posedge clk) disable iff (sys_rst)
    (dina_row[2] == '0) && (dina_row[3] == '0))
    else $error("dina_row lanes 2 and 3 not zero");

endmodule

bind map_top map_top_sva map_top_sva_inst (
  .clk       (clk),
  .sys_rst   (sys_rst),
  .cmd_valid (cmd_valid),
  .busy      (busy),
  .out_valid (out_valid),
  .b_row     (b_row),
  .dina_row  (dina_row)
);

// ==== bench/map_top_tb.sv ====
`timescale 1ns/1ps

module map_top_tb
  import rsa_map_pkg::*;
();

  localparam int NUM_TESTS  = 9;
  localparam int WAIT_LIMIT = 100;
  localparam int TAIL_LEN   = 4;

  logic     clk = 1'b0;
  logic     sys_rst;
  logic     wr_en;
  addr_t    wr_addr;
  row_t     wr_row;
  logic     cmd_valid;
  map_cmd_t cmd;
  logic     busy;
  logic     out_valid;
  row_t     b_row;
  row_t     dina_row;

  // model copy of the bank, and the command table
  row_t        bank_model [BANK_ROWS];
  string       test_name [NUM_TESTS];
  map_cmd_t    test_cmd [NUM_TESTS];
  int          test_busy [NUM_TESTS];
  map_cmd_t    decoy_cmd;
  logic [16:0] lfsr;
  int          err_cnt;
  int          check_cnt;
  int          fail_tests;
  logic        timed_out;

  map_top map_top_inst (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_row    (wr_row),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .busy      (busy),
    .out_valid (out_valid),
    .b_row     (b_row),
    .dina_row  (dina_row)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  // fibonacci, taps 17 and 14
  function automatic logic [16:0] lfsr_next(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
  endfunction

  task automatic random_lane(output lane_t v);
    v = '0;
    for (int b = 0; b < RSA_DW; b++) begin
      v    = {v[RSA_DW-2:0], lfsr[16]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  function automatic map_cmd_t make_cmd(input grp_t g, input dir_t d, input logic flag,
                                        input addr_t base);
    map_cmd_t c;
    c.sel   = {g, d};
    c.l_k_0 = flag;
    c.base  = base;
    return c;
  endfunction

  task automatic set_entry(input int i, input string name, input map_cmd_t c);
    test_name[i] = name;
    test_cmd[i]  = c;
    test_busy[i] = SEQ_LEN;
  endtask

  function automatic row_t low_pair(input lane_t lo, input lane_t hi);
    row_t r;
    r    = '0;
    r[0] = lo;
    r[1] = hi;
    return r;
  endfunction

  // bank row read at step k, address wraps mod 16
  function automatic row_t step_row(input addr_t base, input int k);
    return bank_model[addr_t'(int'(base) + k)];
  endfunction

  function automatic row_t expect_b(input sel_t s, input logic flag, input row_t d);
    row_t r;
    r = '0;
    if (s[4:2] == GRP_B) begin
      case (s[1:0])
        DIR_POS: r = d;
        DIR_NEG: r = {d[0], d[1], d[2], d[3]};
        DIR_NEW: r = flag ? low_pair(d[0], d[1]) : low_pair(d[2], d[3]);
        default: r = '0;
      endcase
    end
    return r;
  endfunction

  function automatic row_t expect_dina(input sel_t s, input logic flag, input addr_t base,
                                       input int k);
    row_t d;
    row_t r6;
    row_t r7;
    row_t r8;
    row_t r;
    d  = step_row(base, k);
    r6 = step_row(base, 6);
    r7 = step_row(base, 7);
    r8 = step_row(base, 8);
    r  = '0;
    if (s[4:2] == GRP_H_TRANSPOSE) begin
      case (k)
        12: r = low_pair(d[0], '0);
        13: r = low_pair(d[1], d[0]);
        14: r = low_pair('0, d[1]);
        default: r = '0;
      endcase
    end else if (s[4:2] == GRP_COV_TRANSPOSE) begin
      // landmark case replays rows 6 to 8 at counts 8 to 10
      case (k)
        4: r = low_pair(d[0], '0);
        5: r = low_pair(d[1], d[0]);
        6: r = low_pair(d[2], d[1]);
        7: r = low_pair('0, d[2]);
        8: r = flag ? low_pair(r6[0], '0) : low_pair(d[2], '0);
        9: r = flag ? low_pair(r7[1], r7[0]) : low_pair(d[3], d[2]);
        10: r = flag ? low_pair('0, r8[1]) : low_pair('0, d[3]);
        default: r = '0;
      endcase
    end
    return r;
  endfunction

  task automatic check_row(input string what, input row_t exp, input row_t act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("[ERROR] %s: expected %h actual %h", what, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("[ERROR] %s: expected %b actual %b", what, exp, act);
    end
  endtask

  // n counts falling edges after the command was driven
  task automatic check_cycle(input string name, input int n, input int busy_len);
    check_bit($sformatf("%s cycle %0d busy", name, n), n <= busy_len, busy);
    check_bit($sformatf("%s cycle %0d out_valid", name, n), n >= 3 && n < 3 + SEQ_LEN,
              out_valid);
    if (!out_valid) begin
      check_row($sformatf("%s cycle %0d b_row", name, n), '0, b_row);
      check_row($sformatf("%s cycle %0d dina_row", name, n), '0, dina_row);
    end
  endtask

  task automatic report_test(input string name, input int errs0);
    if (err_cnt == errs0 && !timed_out) begin
      $display("test %s: ok", name);
    end else begin
      fail_tests++;
      $display("test %s: %0d mismatches%s", name, err_cnt - errs0,
               timed_out ? ", timed out" : "");
    end
  endtask

  task automatic preload_bank();
    row_t  r;
    lane_t v;
    for (int a = 0; a < BANK_ROWS; a++) begin
      for (int l = 0; l < LANES; l++) begin
        random_lane(v);
        r[l] = v;
      end
      @(negedge clk);
      wr_en         = 1'b1;
      wr_addr       = addr_t'(a);
      wr_row        = r;
      bank_model[a] = r;
    end
    @(negedge clk);
    wr_en = 1'b0;
  endtask

  task automatic wait_idle(input string name);
    int n;
    n = 0;
    while (busy && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (busy) begin
      $display("timeout: busy never dropped before test %s", name);
      timed_out = 1'b1;
    end
  endtask

  task automatic run_test(input int idx);
    string    name;
    map_cmd_t c;
    int       n;
    int       errs0;
    logic     seen;
    name  = test_name[idx];
    c     = test_cmd[idx];
    errs0 = err_cnt;
    preload_bank();
    wait_idle(name);
    if (!timed_out) begin
      cmd_valid = 1'b1;
      cmd       = c;
      n         = 0;
      seen      = 1'b0;
      while (!seen && n < WAIT_LIMIT) begin
        @(negedge clk);
        n++;
        // decoy strobe lands while busy
        cmd_valid = (n == 1);
        cmd       = (n == 1) ? decoy_cmd : '0;
        check_cycle(name, n, test_busy[idx]);
        seen = out_valid;
      end
      if (!seen) begin
        $display("timeout: out_valid never rose in test %s", name);
        timed_out = 1'b1;
      end else begin
        for (int k = 0; k < SEQ_LEN; k++) begin
          if (k > 0) begin
            @(negedge clk);
            n++;
            check_cycle(name, n, test_busy[idx]);
          end
          check_row($sformatf("%s step %0d b_row", name, k),
                    expect_b(c.sel, c.l_k_0, step_row(c.base, k)), b_row);
          check_row($sformatf("%s step %0d dina_row", name, k),
                    expect_dina(c.sel, c.l_k_0, c.base, k), dina_row);
        end
        // no second window from the dropped strobe
        repeat (TAIL_LEN) begin
          @(negedge clk);
          n++;
          check_cycle(name, n, test_busy[idx]);
        end
      end
    end
    report_test(name, errs0);
  endtask

  initial begin
    int errs0;
    sys_rst    = 1'b1;
    wr_en      = 1'b0;
    wr_addr    = '0;
    wr_row     = '0;
    cmd_valid  = 1'b0;
    cmd        = '0;
    lfsr       = 17'd75072;
    err_cnt    = 0;
    check_cnt  = 0;
    fail_tests = 0;
    timed_out  = 1'b0;
    decoy_cmd  = make_cmd(GRP_B, DIR_POS, 1'b1, 4'd8);
    set_entry(0, "b_dir_idle", make_cmd(GRP_B, DIR_IDLE, 1'b0, 4'd0));
    set_entry(1, "b_pos", make_cmd(GRP_B, DIR_POS, 1'b0, 4'd5));
    set_entry(2, "b_neg", make_cmd(GRP_B, DIR_NEG, 1'b1, 4'd9));
    set_entry(3, "b_new_lk0", make_cmd(GRP_B, DIR_NEW, 1'b0, 4'd2));
    set_entry(4, "b_new_lk1", make_cmd(GRP_B, DIR_NEW, 1'b1, 4'd14));
    set_entry(5, "h_transpose", make_cmd(GRP_H_TRANSPOSE, DIR_POS, 1'b0, 4'd7));
    set_entry(6, "cov_lk0", make_cmd(GRP_COV_TRANSPOSE, DIR_POS, 1'b0, 4'd11));
    set_entry(7, "cov_lk1", make_cmd(GRP_COV_TRANSPOSE, DIR_NEW, 1'b1, 4'd3));
    set_entry(8, "idle_group", make_cmd(GRP_IDLE, DIR_POS, 1'b1, 4'd0));
    repeat (3) @(negedge clk);
    sys_rst = 1'b0;
    @(negedge clk);
    // state straight out of reset
    errs0 = err_cnt;
    check_bit("reset busy", 1'b0, busy);
    check_bit("reset out_valid", 1'b0, out_valid);
    check_row("reset b_row", '0, b_row);
    check_row("reset dina_row", '0, dina_row);
    report_test("reset", errs0);
    for (int i = 0; i < NUM_TESTS; i++) begin
      if (!timed_out) begin
        run_test(i);
      end
    end
    $display("tests %0d, failing %0d, checks %0d, errors %0d", NUM_TESTS + 1, fail_tests,
             check_cnt, err_cnt);
    if (err_cnt == 0 && !timed_out) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
hw/rsa_map_pkg.sv
hw/tb_bank.sv
hw/map_ctrl_regs.sv
hw/tb_doutb_map.sv
hw/map_top.sv
bench/map_top_sva.sv
bench/map_top_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only --timing -Wall
TOP       = map_top_tb
FILELIST  = compile.f
OBJDIR    = obj_dir
PASS_MSG  = TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# status comes from the grep, so a missing pass line fails make
run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
